// File: rv_isa_pkg.sv
package rv_isa_pkg;

  // base opcodes handled by the core
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111
  } opcode_t;

  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND
  } alu_op_t;

  // funct3 groups for OP and OP_IMM
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;

  // funct7 bit that picks sub / sra
  localparam int F7_ALT_BIT = 5;

  typedef struct packed {
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
    logic [2:0]  funct3;
    logic [6:0]  funct7;
    logic [31:0] i_imm;
    logic [31:0] u_imm;
  } decoded_t;

endpackage

// File: pipe_pkg.sv
package pipe_pkg;

  localparam int XLEN   = 32;
  localparam int NREG   = 32;
  localparam int REG_AW = 5;

  // operand and result mux selects
  typedef enum logic {
    OPA_RS1,
    OPA_PC
  } op_a_sel_t;

  typedef enum logic [1:0] {
    OPB_RS2,
    OPB_I_IMM,
    OPB_U_IMM
  } op_b_sel_t;

  typedef enum logic {
    RES_ALU,
    RES_U_IMM
  } res_sel_t;

  // control word built in decode, consumed in execute
  typedef struct packed {
    rv_isa_pkg::alu_op_t alu_op;
    op_a_sel_t           op_a_sel;
    op_b_sel_t           op_b_sel;
    res_sel_t            res_sel;
    logic                rd_we;
  } ctrl_t;

  typedef struct packed {
    logic [XLEN-1:0]      pc;
    logic [XLEN-1:0]      rs1_val;
    logic [XLEN-1:0]      rs2_val;
    rv_isa_pkg::decoded_t dec;
    ctrl_t                ctrl;
  } idex_t;

  // shared by EX/MEM and MEM/WB
  typedef struct packed {
    logic [REG_AW-1:0] rd;
    logic              rd_we;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   pc;
  } exwb_t;

  typedef struct packed {
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rd;
    logic              rd_we;
    logic [XLEN-1:0]   value;
  } retire_t;

endpackage

// File: pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     arst_n,
  input  logic     in_valid,
  input  payload_t in_data,
  output logic     out_valid,
  output payload_t out_data
);

  // valid advances every clock, no stall or flush
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      out_valid <= 1'b0;
    end else begin
      out_valid <= in_valid;
    end
  end

  // payload only moves with a valid slot
  always_ff @(posedge clk) begin
    if (in_valid) begin
      out_data <= in_data;
    end
  end

  valid_known_a: assert property (
    @(posedge clk) disable iff (!arst_n) !$isunknown(out_valid)
  ) else $error("pipe_reg: out_valid unknown after reset");

endmodule

// File: regfile.sv
`timescale 1ns/1ps

module regfile (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        we,
  input  logic [pipe_pkg::REG_AW-1:0] waddr,
  input  logic [pipe_pkg::XLEN-1:0]   wdata,
  input  logic [pipe_pkg::REG_AW-1:0] raddr_a,
  input  logic [pipe_pkg::REG_AW-1:0] raddr_b,
  output logic [pipe_pkg::XLEN-1:0]   rdata_a,
  output logic [pipe_pkg::XLEN-1:0]   rdata_b
);

  // x0 has no storage
  logic [pipe_pkg::XLEN-1:0] regs [1:pipe_pkg::NREG-1];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 1; i < pipe_pkg::NREG; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  // read port with write-through for same-cycle writeback
  function automatic logic [pipe_pkg::XLEN-1:0] read_port(
    input logic [pipe_pkg::REG_AW-1:0] addr
  );
    logic [pipe_pkg::XLEN-1:0] val;
    if (addr == '0) begin
      val = '0;
    end else if (we && waddr == addr) begin
      val = wdata;
    end else begin
      val = regs[addr];
    end
    return val;
  endfunction

  always_comb begin
    rdata_a = read_port(raddr_a);
    rdata_b = read_port(raddr_b);
  end

  // decode must never flag a write to x0
  no_x0_write_a: assert property (
    @(posedge clk) disable iff (!arst_n) we |-> (waddr != '0)
  ) else $error("regfile: write targets x0");

endmodule

// File: decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
  input  logic                        clk,
  input  logic                        arst_n,
  input  logic                        instr_valid,
  input  logic [31:0]                 instr,
  output logic [pipe_pkg::REG_AW-1:0] rf_raddr_a,
  output logic [pipe_pkg::REG_AW-1:0] rf_raddr_b,
  input  logic [pipe_pkg::XLEN-1:0]   rf_rdata_a,
  input  logic [pipe_pkg::XLEN-1:0]   rf_rdata_b,
  output logic                        idex_valid,
  output pipe_pkg::idex_t             idex
);

  typedef struct packed {
    logic [31:0]               instr;
    logic [pipe_pkg::XLEN-1:0] pc;
  } ifid_t;

  logic [pipe_pkg::XLEN-1:0] pc_q;
  ifid_t                     ifid_in;
  ifid_t                     ifid;
  logic                      ifid_valid;
  rv_isa_pkg::opcode_t       opcode;
  rv_isa_pkg::decoded_t      dec;
  pipe_pkg::ctrl_t           ctrl;
  logic                      legal;

  //**********************************************************
  // fetch capture
  //**********************************************************

  // pc steps once per accepted strobe
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pc_q <= '0;
    end else if (instr_valid) begin
      pc_q <= pc_q + pipe_pkg::XLEN'(4);
    end
  end

  assign ifid_in = '{instr: instr, pc: pc_q};

  pipe_reg #(.payload_t(ifid_t))
  pipe_ifid (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (instr_valid),
    .in_data   (ifid_in),
    .out_valid (ifid_valid),
    .out_data  (ifid)
  );

  //**********************************************************
  // field split and control word
  //**********************************************************

  function automatic rv_isa_pkg::decoded_t split_fields(input logic [31:0] w);
    rv_isa_pkg::decoded_t d;
    d.rs1    = w[19:15];
    d.rs2    = w[24:20];
    d.rd     = w[11:7];
    d.funct3 = w[14:12];
    d.funct7 = w[31:25];
    d.i_imm  = {{20{w[31]}}, w[31:20]};
    d.u_imm  = {w[31:12], 12'h000};
    return d;
  endfunction

  // sub only exists in the register form
  function automatic rv_isa_pkg::alu_op_t alu_sel(
    input logic [2:0] f3,
    input logic       alt,
    input logic       is_reg
  );
    rv_isa_pkg::alu_op_t op;
    case (f3)
      rv_isa_pkg::F3_ADD_SUB: op = (is_reg && alt) ? rv_isa_pkg::ALU_SUB : rv_isa_pkg::ALU_ADD;
      rv_isa_pkg::F3_SLL:     op = rv_isa_pkg::ALU_SLL;
      rv_isa_pkg::F3_SLT:     op = rv_isa_pkg::ALU_SLT;
      rv_isa_pkg::F3_SLTU:    op = rv_isa_pkg::ALU_SLTU;
      rv_isa_pkg::F3_XOR:     op = rv_isa_pkg::ALU_XOR;
      rv_isa_pkg::F3_SRL_SRA: op = alt ? rv_isa_pkg::ALU_SRA : rv_isa_pkg::ALU_SRL;
      rv_isa_pkg::F3_OR:      op = rv_isa_pkg::ALU_OR;
      default:                op = rv_isa_pkg::ALU_AND;
    endcase
    return op;
  endfunction

  assign opcode = rv_isa_pkg::opcode_t'(ifid.instr[6:0]);
  assign dec    = split_fields(ifid.instr);

  always_comb begin
    ctrl.alu_op   = rv_isa_pkg::ALU_ADD;
    ctrl.op_a_sel = pipe_pkg::OPA_RS1;
    ctrl.op_b_sel = pipe_pkg::OPB_RS2;
    ctrl.res_sel  = pipe_pkg::RES_ALU;
    legal         = 1'b1;
    case (opcode)
      rv_isa_pkg::OPC_OP: begin
        ctrl.alu_op = alu_sel(dec.funct3, dec.funct7[rv_isa_pkg::F7_ALT_BIT], 1'b1);
      end
      rv_isa_pkg::OPC_OP_IMM: begin
        ctrl.alu_op   = alu_sel(dec.funct3, dec.funct7[rv_isa_pkg::F7_ALT_BIT], 1'b0);
        ctrl.op_b_sel = pipe_pkg::OPB_I_IMM;
      end
      rv_isa_pkg::OPC_LUI: begin
        ctrl.res_sel = pipe_pkg::RES_U_IMM;
      end
      rv_isa_pkg::OPC_AUIPC: begin
        ctrl.op_a_sel = pipe_pkg::OPA_PC;
        ctrl.op_b_sel = pipe_pkg::OPB_U_IMM;
      end
      default: legal = 1'b0;
    endcase
    // unknown opcodes still flow, just never write
    ctrl.rd_we = legal && (dec.rd != '0);
  end

  // register read
  assign rf_raddr_a = dec.rs1;
  assign rf_raddr_b = dec.rs2;

  assign idex_valid = ifid_valid;
  assign idex = '{
    pc:      ifid.pc,
    rs1_val: rf_rdata_a,
    rs2_val: rf_rdata_b,
    dec:     dec,
    ctrl:    ctrl
  };

endmodule

// File: alu.sv
`timescale 1ns/1ps

module alu (
  input  rv_isa_pkg::alu_op_t       op,
  input  logic [pipe_pkg::XLEN-1:0] a,
  input  logic [pipe_pkg::XLEN-1:0] b,
  output logic [pipe_pkg::XLEN-1:0] y
);

  logic [4:0] shamt;

  // only the low 5 bits shift
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      rv_isa_pkg::ALU_ADD:  y = a + b;
      rv_isa_pkg::ALU_SUB:  y = a - b;
      rv_isa_pkg::ALU_SLL:  y = a << shamt;
      rv_isa_pkg::ALU_SLT:  y = pipe_pkg::XLEN'($signed(a) < $signed(b));
      rv_isa_pkg::ALU_SLTU: y = pipe_pkg::XLEN'(a < b);
      rv_isa_pkg::ALU_XOR:  y = a ^ b;
      rv_isa_pkg::ALU_SRL:  y = a >> shamt;
      rv_isa_pkg::ALU_SRA:  y = $unsigned($signed(a) >>> shamt);
      rv_isa_pkg::ALU_OR:   y = a | b;
      rv_isa_pkg::ALU_AND:  y = a & b;
      default:              y = '0;
    endcase
  end

endmodule

// File: execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
  input  logic              idex_valid,
  input  pipe_pkg::idex_t   idex,
  input  logic              exmem_valid,
  input  pipe_pkg::exwb_t   exmem,
  input  logic              memwb_valid,
  input  pipe_pkg::exwb_t   memwb,
  output logic              ex_valid,
  output pipe_pkg::exwb_t   ex
);

  logic [pipe_pkg::XLEN-1:0] rs1_fwd;
  logic [pipe_pkg::XLEN-1:0] rs2_fwd;
  logic [pipe_pkg::XLEN-1:0] op_a;
  logic [pipe_pkg::XLEN-1:0] op_b;
  logic [pipe_pkg::XLEN-1:0] alu_y;
  logic [pipe_pkg::XLEN-1:0] result;

  //**********************************************************
  // forwarding
  //**********************************************************

  // youngest older writer wins, EX/MEM before MEM/WB
  function automatic logic [pipe_pkg::XLEN-1:0] forward(
    input logic [pipe_pkg::REG_AW-1:0] src,
    input logic [pipe_pkg::XLEN-1:0]   rf_val,
    input logic                        em_valid,
    input pipe_pkg::exwb_t             em,
    input logic                        mw_valid,
    input pipe_pkg::exwb_t             mw
  );
    logic [pipe_pkg::XLEN-1:0] val;
    val = rf_val;
    if (mw_valid && mw.rd_we && mw.rd == src) begin
      val = mw.result;
    end
    if (em_valid && em.rd_we && em.rd == src) begin
      val = em.result;
    end
    return val;
  endfunction

  assign rs1_fwd = forward(idex.dec.rs1, idex.rs1_val, exmem_valid, exmem, memwb_valid, memwb);
  assign rs2_fwd = forward(idex.dec.rs2, idex.rs2_val, exmem_valid, exmem, memwb_valid, memwb);

  //**********************************************************
  // operand and result muxes
  //**********************************************************

  always_comb begin
    case (idex.ctrl.op_a_sel)
      pipe_pkg::OPA_PC: op_a = idex.pc;
      default:          op_a = rs1_fwd;
    endcase

    case (idex.ctrl.op_b_sel)
      pipe_pkg::OPB_I_IMM: op_b = idex.dec.i_imm;
      pipe_pkg::OPB_U_IMM: op_b = idex.dec.u_imm;
      default:             op_b = rs2_fwd;
    endcase

    // selects come from decode, check them while they matter
    if (idex_valid) begin
      sel_legal_a: assert (!$isunknown({idex.ctrl.op_a_sel, idex.ctrl.res_sel}) &&
                           idex.ctrl.op_b_sel inside {pipe_pkg::OPB_RS2,
                                                      pipe_pkg::OPB_I_IMM,
                                                      pipe_pkg::OPB_U_IMM})
        else $error("execute_stage: illegal mux select");
    end
  end

  alu alu0 (
    .op (idex.ctrl.alu_op),
    .a  (op_a),
    .b  (op_b),
    .y  (alu_y)
  );

  // lui bypasses the alu
  assign result = (idex.ctrl.res_sel == pipe_pkg::RES_U_IMM) ? idex.dec.u_imm : alu_y;

  assign ex_valid = idex_valid;
  assign ex = '{
    rd:     idex.dec.rd,
    rd_we:  idex.ctrl.rd_we,
    result: result,
    pc:     idex.pc
  };

endmodule

// File: writeback_stage.sv
`timescale 1ns/1ps

module writeback_stage (
  input  logic                        memwb_valid,
  input  pipe_pkg::exwb_t             memwb,
  output logic                        rf_we,
  output logic [pipe_pkg::REG_AW-1:0] rf_waddr,
  output logic [pipe_pkg::XLEN-1:0]   rf_wdata,
  output logic                        retire_valid,
  output pipe_pkg::retire_t           retire
);

  // write only for a live slot that asks for it
  assign rf_we    = memwb_valid && memwb.rd_we;
  assign rf_waddr = memwb.rd;
  assign rf_wdata = memwb.result;

  //**********************************************************
  // retire record
  //**********************************************************

  assign retire_valid = memwb_valid;
  assign retire = '{
    pc:    memwb.pc,
    rd:    memwb.rd,
    rd_we: rf_we,
    value: memwb.result
  };

  // rd_we was cleared for x0 back in decode
  always_comb begin
    if (retire_valid && retire.rd_we) begin
      rd_nonzero_a: assert (retire.rd != '0)
        else $error("writeback_stage: retire writes x0");
    end
  end

endmodule

// File: rv_core_top.sv
`timescale 1ns/1ps

module rv_core_top (
  input  logic              clk,
  input  logic              arst_n,
  input  logic              instr_valid,
  input  logic [31:0]       instr,
  output logic              retire_valid,
  output pipe_pkg::retire_t retire
);

  logic [pipe_pkg::REG_AW-1:0] rf_raddr_a;
  logic [pipe_pkg::REG_AW-1:0] rf_raddr_b;
  logic [pipe_pkg::XLEN-1:0]   rf_rdata_a;
  logic [pipe_pkg::XLEN-1:0]   rf_rdata_b;
  logic                        rf_we;
  logic [pipe_pkg::REG_AW-1:0] rf_waddr;
  logic [pipe_pkg::XLEN-1:0]   rf_wdata;
  logic                        dec_valid;
  pipe_pkg::idex_t             dec_idex;
  logic                        idex_valid;
  pipe_pkg::idex_t             idex;
  logic                        ex_valid;
  pipe_pkg::exwb_t             ex;
  logic                        exmem_valid;
  pipe_pkg::exwb_t             exmem;
  logic                        memwb_valid;
  pipe_pkg::exwb_t             memwb;

  //**********************************************************
  // input side
  //**********************************************************

  decode_stage decode0 (
    .clk         (clk),
    .arst_n      (arst_n),
    .instr_valid (instr_valid),
    .instr       (instr),
    .rf_raddr_a  (rf_raddr_a),
    .rf_raddr_b  (rf_raddr_b),
    .rf_rdata_a  (rf_rdata_a),
    .rf_rdata_b  (rf_rdata_b),
    .idex_valid  (dec_valid),
    .idex        (dec_idex)
  );

  regfile regfile0 (
    .clk     (clk),
    .arst_n  (arst_n),
    .we      (rf_we),
    .waddr   (rf_waddr),
    .wdata   (rf_wdata),
    .raddr_a (rf_raddr_a),
    .raddr_b (rf_raddr_b),
    .rdata_a (rf_rdata_a),
    .rdata_b (rf_rdata_b)
  );

  pipe_reg #(.payload_t(pipe_pkg::idex_t))
  pipe_idex (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (dec_valid),
    .in_data   (dec_idex),
    .out_valid (idex_valid),
    .out_data  (idex)
  );

  //**********************************************************
  // processing and output side
  //**********************************************************

  execute_stage execute0 (
    .idex_valid  (idex_valid),
    .idex        (idex),
    .exmem_valid (exmem_valid),
    .exmem       (exmem),
    .memwb_valid (memwb_valid),
    .memwb       (memwb),
    .ex_valid    (ex_valid),
    .ex          (ex)
  );

  pipe_reg #(.payload_t(pipe_pkg::exwb_t))
  pipe_exmem (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (ex_valid),
    .in_data   (ex),
    .out_valid (exmem_valid),
    .out_data  (exmem)
  );

  // memory slot, data only
  pipe_reg #(.payload_t(pipe_pkg::exwb_t))
  pipe_memwb (
    .clk       (clk),
    .arst_n    (arst_n),
    .in_valid  (exmem_valid),
    .in_data   (exmem),
    .out_valid (memwb_valid),
    .out_data  (memwb)
  );

  writeback_stage writeback0 (
    .memwb_valid  (memwb_valid),
    .memwb        (memwb),
    .rf_we        (rf_we),
    .rf_waddr     (rf_waddr),
    .rf_wdata     (rf_wdata),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

endmodule

// File: tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core;

  localparam int          NUM_INSTR      = 400;
  localparam int          TIMEOUT_CYCLES = NUM_INSTR * 3 + 50;
  localparam logic [31:0] SEED           = 32'd19295;

  // one expected retire plus when it must show up
  typedef struct packed {
    pipe_pkg::retire_t rec;
    logic              chk;
    logic [31:0]       cyc;
  } expect_t;

  logic              clk;
  logic              arst_n;
  logic              instr_valid;
  logic [31:0]       instr;
  logic              retire_valid;
  pipe_pkg::retire_t retire;

  logic [31:0] lcg_state;
  logic [31:0] xreg [32];
  logic [31:0] model_pc;
  expect_t     exp_q [$];
  expect_t     got_exp;
  int          cycle = 0;
  int unsigned gap;

  rv_core_top dut0 (
    .clk          (clk),
    .arst_n       (arst_n),
    .instr_valid  (instr_valid),
    .instr        (instr),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  initial clk = 1'b0;
  always #4 clk = ~clk;

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= TIMEOUT_CYCLES) begin
      $display("Something failed");
      $fatal(1, "timeout, the run did not finish after %0d cycles", cycle);
    end
  end

  //**********************************************************
  // random numbers and checking
  //**********************************************************

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  // upper bits only since the low ones cycle too fast
  function automatic int unsigned rand_below(input int unsigned n);
    return (next_rand() >> 8) % n;
  endfunction

  // mostly x0..x7 so that hazards are frequent
  function automatic logic [4:0] pick_reg();
    if (rand_below(8) == 0) begin
      return 5'(rand_below(32));
    end
    return 5'(rand_below(8));
  endfunction

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp) begin
      $display("error at %0t: %s mismatch, got 0x%08h expected 0x%08h", $time, what, got, exp);
      $display("Something failed");
      $fatal(1, "value mismatch");
    end
  endtask

  //**********************************************************
  // ISA reference model
  //**********************************************************

  function automatic logic [31:0] isa_result(input logic [2:0] f3, input logic alt,
                                             input logic [31:0] a, input logic [31:0] b);
    logic [4:0]  sh;
    logic [31:0] r;
    sh = b[4:0];
    case (f3)
      3'b000: r = alt ? a - b : a + b;
      3'b001: r = a << sh;
      3'b010: r = (a[31] != b[31]) ? {31'd0, a[31]} : {31'd0, a < b};
      3'b011: r = {31'd0, a < b};
      3'b100: r = a ^ b;
      // arithmetic shift as logical shift plus sign fill
      3'b101: r = alt ? ((a >> sh) | (a[31] ? ~(32'hffffffff >> sh) : 32'd0)) : a >> sh;
      3'b110: r = a | b;
      default: r = a & b;
    endcase
    return r;
  endfunction

  // builds one instruction, runs it on the model, drives it
  task automatic send_instr();
    logic [31:0] w;
    logic [31:0] tmp;
    logic [4:0]  rd;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm12;
    logic [19:0] imm20;
    logic [31:0] value;
    logic        legal;
    int unsigned cls;
    expect_t     e;
    rd    = pick_reg();
    rs1   = pick_reg();
    rs2   = pick_reg();
    f3    = 3'(rand_below(8));
    legal = 1'b1;
    value = 32'd0;
    cls   = rand_below(10);
    if (cls < 4) begin
      f7 = ((f3 == 3'b000 || f3 == 3'b101) && rand_below(2) == 1) ? 7'h20 : 7'h00;
      w = {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
      value = isa_result(f3, f7[5], xreg[rs1], xreg[rs2]);
    end else if (cls < 7) begin
      if (f3 == 3'b001 || f3 == 3'b101) begin
        f7 = (f3 == 3'b101 && rand_below(2) == 1) ? 7'h20 : 7'h00;
        imm12 = {f7, 5'(rand_below(32))};
      end else if (rand_below(4) == 0) begin
        imm12 = 12'(rand_below(16));
      end else begin
        imm12 = 12'(next_rand() >> 12);
      end
      w = {imm12, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
      value = isa_result(f3, (f3 == 3'b101) && imm12[10], xreg[rs1],
                         {{20{imm12[11]}}, imm12});
    end else if (cls < 9) begin
      imm20 = 20'(next_rand() >> 8);
      if (cls == 7) begin
        w = {imm20, rd, rv_isa_pkg::OPC_LUI};
        value = {imm20, 12'h000};
      end else begin
        w = {imm20, rd, rv_isa_pkg::OPC_AUIPC};
        value = model_pc + {imm20, 12'h000};
      end
    end else begin
      // opcodes outside the supported set
      tmp = next_rand();
      case (rand_below(4))
        0: w = {tmp[31:7], 7'b0000011};
        1: w = {tmp[31:7], 7'b0100011};
        2: w = {tmp[31:7], 7'b1100011};
        default: w = {tmp[31:7], 7'b1101111};
      endcase
      rd    = w[11:7];
      legal = 1'b0;
    end
    e.rec.pc    = model_pc;
    e.rec.rd    = rd;
    e.rec.rd_we = legal && (rd != 5'd0);
    e.rec.value = value;
    e.chk       = legal;
    e.cyc       = 32'(cycle + 4);
    exp_q.push_back(e);
    if (e.rec.rd_we) begin
      xreg[rd] = value;
    end
    model_pc = model_pc + 32'd4;
    instr       = w;
    instr_valid = 1'b1;
  endtask

  //**********************************************************
  // retire monitor
  //**********************************************************

  always @(negedge clk) begin
    if (arst_n) begin
      if ($isunknown(retire_valid)) begin
        $display("Something failed");
        $fatal(1, "retire_valid is unknown after reset");
      end else if (retire_valid) begin
        if (exp_q.size() == 0) begin
          $display("Something failed");
          $fatal(1, "a retire came out with no instruction sent for it");
        end else begin
          got_exp = exp_q.pop_front();
          check_value(32'(cycle), got_exp.cyc, "retire cycle");
          check_value(retire.pc, got_exp.rec.pc, "retire pc");
          check_value(32'(retire.rd), 32'(got_exp.rec.rd), "retire rd");
          check_value(32'(retire.rd_we), 32'(got_exp.rec.rd_we), "retire rd_we");
          if (got_exp.chk) begin
            check_value(retire.value, got_exp.rec.value, "retire value");
          end
        end
      end
    end
  end

  initial begin
    arst_n      = 1'b0;
    instr_valid = 1'b0;
    instr       = 32'd0;
    lcg_state   = SEED;
    model_pc    = 32'd0;
    for (int i = 0; i < 32; i++) begin
      xreg[i] = 32'd0;
    end
    repeat (5) @(posedge clk);
    #1 arst_n = 1'b1;
    // idle window after reset where nothing may retire
    repeat (3) @(posedge clk);
    for (int n = 0; n < NUM_INSTR; n++) begin
      @(posedge clk);
      #1;
      send_instr();
      gap = rand_below(4);
      if (gap == 3) begin
        gap = 0;
      end
      repeat (gap) begin
        @(posedge clk);
        #1;
        instr_valid = 1'b0;
        instr       = next_rand();
      end
    end
    @(posedge clk);
    #1 instr_valid = 1'b0;
    // last strobe retires 4 cycles later
    repeat (6) @(posedge clk);
    if (exp_q.size() == 0) begin
      $display("Everything OK");
      $finish;
    end else begin
      $display("Something failed");
      $fatal(1, "instructions were sent that never retired");
    end
  end

endmodule

// File: project.f
rv_isa_pkg.sv
pipe_pkg.sv
pipe_reg.sv
regfile.sv
decode_stage.sv
alu.sv
execute_stage.sv
writeback_stage.sv
rv_core_top.sv
tb_rv_core.sv

// File: Makefile
# Verilator build and run of the RV32I pipeline testbench

VERILATOR ?= verilator
TOP       ?= tb_rv_core
FILELIST  ?= project.f
OBJ_DIR   ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert -j $(JOBS)

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "variables: VERILATOR TOP FILELIST OBJ_DIR JOBS VFLAGS"

# exit status of the simulation is the test result
test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
